/* src/axis_if.sv */
// Payload stream interface with source and sink modports
`timescale 1ns/1ns
`default_nettype none

interface axis_if import axis_pkg::*; ();

    data_t tdata;
    keep_t tkeep;
    logic  tvalid;
    logic  tready;
    logic  tlast;
    logic  tuser;

    // Side that produces beats
    modport source (
        output tdata, tkeep, tvalid, tlast, tuser,
        input  tready
    );

    // Side that consumes beats and drives back-pressure
    modport sink (
        input  tdata, tkeep, tvalid, tlast, tuser,
        output tready
    );

endinterface

`default_nettype wire

/* src/axis_pkg.sv */
// Payload stream widths, beat types and the header buffer state enum
`default_nettype none

package axis_pkg;

    // 64-bit payload path
    localparam int DATA_BYTES = 8;

    typedef logic [DATA_BYTES*8-1:0] data_t;
    typedef logic [DATA_BYTES-1:0]   keep_t;

    // One stored payload beat
    typedef struct packed {
        data_t data;
        keep_t keep;
        logic  last;
        logic  user;
    } axis_beat_t;

    // Occupancy of the one-entry header buffer
    typedef enum logic {
        BUF_EMPTY = 1'b0,
        BUF_FULL  = 1'b1
    } buf_state_t;

    localparam int LED_WIDTH = 8;

endpackage

`default_nettype wire

/* src/frame_led_capture.sv */
// Frame start tracking on the outgoing payload stream and LED byte latch
`timescale 1ns/1ns
`default_nettype none

module frame_led_capture import axis_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    // Observation only
    axis_if.sink                 mon,
    output logic [LED_WIDTH-1:0] led
);

    logic in_frame;
    logic xfer;
    logic first_beat;

    assign xfer       = mon.tvalid && mon.tready;
    assign first_beat = xfer && !in_frame;

    // Set after a non-last beat, cleared after a last beat
    always_ff @(posedge clk) begin
        if (rst) begin
            in_frame <= 1'b0;
        end else if (xfer) begin
            in_frame <= !mon.tlast;
        end
    end

    // Low byte of the first beat goes to the LEDs
    always_ff @(posedge clk) begin
        if (rst) begin
            led <= '0;
        end else if (first_beat) begin
            led <= mon.tdata[LED_WIDTH-1:0];
        end
    end

endmodule

`default_nettype wire

/* src/udp_hdr_responder.sv */
// One-entry header buffer that turns a received UDP header into the reply header
`timescale 1ns/1ns
`default_nettype none

module udp_hdr_responder import udp_pkg::*, axis_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  ip_addr_t local_ip,
    input  logic     s_hdr_valid,
    input  udp_hdr_t s_hdr,
    output logic     s_hdr_ready,
    output logic     m_hdr_valid,
    output udp_hdr_t m_hdr,
    input  logic     m_hdr_ready
);

    buf_state_t state;
    udp_hdr_t   reply;
    udp_hdr_t   reply_q;
    logic       hdr_accept;

    // Room when empty, or when the held reply leaves this cycle
    assign s_hdr_ready = (state == BUF_EMPTY) || m_hdr_ready;
    assign hdr_accept  = s_hdr_valid && s_hdr_ready;

    // Swap rule for the reply
    always_comb begin
        reply.source_ip   = local_ip;
        reply.dest_ip     = s_hdr.source_ip;
        reply.source_port = s_hdr.dest_port;
        reply.dest_port   = s_hdr.source_port;
        reply.length      = s_hdr.length;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= BUF_EMPTY;
        end else if (hdr_accept) begin
            state <= BUF_FULL;
        end else if (m_hdr_ready) begin
            state <= BUF_EMPTY;
        end
    end

    // Reply register only loads on accept
    always_ff @(posedge clk) begin
        if (hdr_accept) begin
            reply_q <= reply;
        end
    end

    assign m_hdr_valid = (state == BUF_FULL);
    assign m_hdr       = reply_q;

    // A stalled reply keeps its valid and its contents until taken
    property p_hold_under_stall;
        @(posedge clk) disable iff (rst)
        m_hdr_valid && !m_hdr_ready |=> m_hdr_valid && $stable(m_hdr);
    endproperty

    a_hold_under_stall: assert property (p_hold_under_stall)
        else $error("reply header changed while stalled");

endmodule

`default_nettype wire

/* src/udp_loopback_top.sv */
// UDP loop-back top level with plain ports, header responder, payload FIFO and LEDs
`timescale 1ns/1ns
`default_nettype none

module udp_loopback_top import udp_pkg::*, axis_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                 clk,
    input  logic                 rst,

    // Received header
    input  logic                 s_hdr_valid,
    output logic                 s_hdr_ready,
    input  ip_addr_t             s_hdr_source_ip,
    input  ip_addr_t             s_hdr_dest_ip,
    input  udp_port_t            s_hdr_source_port,
    input  udp_port_t            s_hdr_dest_port,
    input  udp_len_t             s_hdr_length,

    // Reply header
    output logic                 m_hdr_valid,
    input  logic                 m_hdr_ready,
    output ip_addr_t             m_hdr_source_ip,
    output ip_addr_t             m_hdr_dest_ip,
    output udp_port_t            m_hdr_source_port,
    output udp_port_t            m_hdr_dest_port,
    output udp_len_t             m_hdr_length,

    // Received payload
    input  data_t                s_payload_tdata,
    input  keep_t                s_payload_tkeep,
    input  logic                 s_payload_tvalid,
    output logic                 s_payload_tready,
    input  logic                 s_payload_tlast,
    input  logic                 s_payload_tuser,

    // Reply payload
    output data_t                m_payload_tdata,
    output keep_t                m_payload_tkeep,
    output logic                 m_payload_tvalid,
    input  logic                 m_payload_tready,
    output logic                 m_payload_tlast,
    output logic                 m_payload_tuser,

    input  ip_addr_t             local_ip,
    output logic [LED_WIDTH-1:0] led
);

    udp_hdr_t rx_hdr;
    udp_hdr_t tx_hdr;

    axis_if rx_payload ();
    axis_if tx_payload ();

    // Header fields in, reply fields out
    always_comb begin
        rx_hdr.length      = s_hdr_length;
        rx_hdr.dest_port   = s_hdr_dest_port;
        rx_hdr.source_port = s_hdr_source_port;
        rx_hdr.dest_ip     = s_hdr_dest_ip;
        rx_hdr.source_ip   = s_hdr_source_ip;
    end

    assign m_hdr_length      = tx_hdr.length;
    assign m_hdr_dest_port   = tx_hdr.dest_port;
    assign m_hdr_source_port = tx_hdr.source_port;
    assign m_hdr_dest_ip     = tx_hdr.dest_ip;
    assign m_hdr_source_ip   = tx_hdr.source_ip;

    // Payload ports onto the streams
    assign rx_payload.tdata  = s_payload_tdata;
    assign rx_payload.tkeep  = s_payload_tkeep;
    assign rx_payload.tvalid = s_payload_tvalid;
    assign rx_payload.tlast  = s_payload_tlast;
    assign rx_payload.tuser  = s_payload_tuser;
    assign s_payload_tready  = rx_payload.tready;

    assign m_payload_tdata   = tx_payload.tdata;
    assign m_payload_tkeep   = tx_payload.tkeep;
    assign m_payload_tvalid  = tx_payload.tvalid;
    assign m_payload_tlast   = tx_payload.tlast;
    assign m_payload_tuser   = tx_payload.tuser;
    assign tx_payload.tready = m_payload_tready;

    udp_hdr_responder u_udp_hdr_responder (
        .clk         (clk),
        .rst         (rst),
        .local_ip    (local_ip),
        .s_hdr_valid (s_hdr_valid),
        .s_hdr       (rx_hdr),
        .s_hdr_ready (s_hdr_ready),
        .m_hdr_valid (m_hdr_valid),
        .m_hdr       (tx_hdr),
        .m_hdr_ready (m_hdr_ready)
    );

    udp_payload_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_udp_payload_fifo (
        .clk    (clk),
        .rst    (rst),
        .s_axis (rx_payload.sink),
        .m_axis (tx_payload.source)
    );

    // Watches the outgoing stream only
    frame_led_capture u_frame_led_capture (
        .clk (clk),
        .rst (rst),
        .mon (tx_payload.sink),
        .led (led)
    );

endmodule

`default_nettype wire

/* src/udp_payload_fifo.sv */
// Parameterized synchronous payload FIFO with occupancy assertions
`timescale 1ns/1ns
`default_nettype none

module udp_payload_fifo import axis_pkg::*; #(
    // Power of two, at least 2
    parameter int DEPTH = 16
) (
    input logic  clk,
    input logic  rst,
    axis_if.sink   s_axis,
    axis_if.source m_axis
);

    localparam int AW = $clog2(DEPTH);

    axis_beat_t mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;

    axis_beat_t wr_beat;
    axis_beat_t rd_beat;
    logic       push;
    logic       pop;

    // Input side
    assign s_axis.tready = (count < DEPTH);
    assign push          = s_axis.tvalid && s_axis.tready;

    always_comb begin
        wr_beat.data = s_axis.tdata;
        wr_beat.keep = s_axis.tkeep;
        wr_beat.last = s_axis.tlast;
        wr_beat.user = s_axis.tuser;
    end

    // Output side reads the head entry directly
    assign rd_beat       = mem[rd_ptr];
    assign m_axis.tvalid = (count != 0);
    assign m_axis.tdata  = rd_beat.data;
    assign m_axis.tkeep  = rd_beat.keep;
    assign m_axis.tlast  = rd_beat.last;
    assign m_axis.tuser  = rd_beat.user;
    assign pop           = m_axis.tvalid && m_axis.tready;

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_beat;
        end
    end

    // Pointers wrap naturally at DEPTH
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Occupancy stays within the memory
    a_count_bound: assert property (
        @(posedge clk) disable iff (rst) count <= DEPTH
    ) else $error("FIFO count above depth");

    // A read needs stored data, judged from the pointers
    a_no_empty_read: assert property (
        @(posedge clk) disable iff (rst)
        pop |-> (rd_ptr != wr_ptr) || (count == DEPTH)
    ) else $error("FIFO read while empty");

endmodule

`default_nettype wire

/* src/udp_pkg.sv */
// UDP/IP header field types and the packed reply header struct
`default_nettype none

package udp_pkg;

    // IPv4 address
    typedef logic [31:0] ip_addr_t;

    // UDP port number
    typedef logic [15:0] udp_port_t;

    // UDP length field
    typedef logic [15:0] udp_len_t;

    // Header bundle with length in the top bits and source IP in the bottom bits
    typedef struct packed {
        udp_len_t  length;
        udp_port_t dest_port;
        udp_port_t source_port;
        ip_addr_t  dest_ip;
        ip_addr_t  source_ip;
    } udp_hdr_t;

endpackage

`default_nettype wire

/* tests/loopback_input.txt */
# F src_ip dst_ip src_port dst_port length beats | reply src_ip dst_ip src_port dst_port length led
# B data keep user   (one line per payload beat, last flag follows from the beat count)
F c0a80164 0a000080 d431 04d2 0028 4 0a000080 c0a80164 04d2 d431 0028 11
B 0706050403020111 ff 0
B 0f0e0d0c0b0a0908 ff 0
B 1716151413121110 ff 0
B 1f1e1d1c1b1a1918 ff 0
F c0a80165 0a000080 1f90 04d2 000d 1 0a000080 c0a80165 04d2 1f90 000d 42
B 000000aabbccdd42 1f 1
F ac100a07 0a000080 3039 0035 0036 6 0a000080 ac100a07 0035 3039 0036 0d
B deadbeefcafef00d ff 0
B 0123456789abcdef ff 0
B fedcba9876543210 ff 0
B 5a5a5a5aa5a5a5a5 ff 0
B 0f1e2d3c4b5a6978 ff 0
B 0000778899aabbcc 3f 0
F 08080808 0a000080 0101 ffff 003a 7 0a000080 08080808 ffff 0101 003a 77
B 1111111111111177 ff 0
B 2222222222222222 ff 0
B 3333333333333333 ff 0
B 4444444444444444 ff 0
B 5555555555555555 ff 0
B 6666666666666666 ff 0
B 000000000000abcd 03 1

/* tests/tb_loopback_checker.sv */
// Output checker comparing reply headers, payload beats and LED bytes with queued expectations
`timescale 1ns/1ns
`default_nettype none

module tb_loopback_checker import udp_pkg::*, axis_pkg::*; (
    input logic                 clk,
    input logic                 rst,
    input logic                 s_hdr_ready,
    input logic                 s_payload_tvalid,
    input logic                 s_payload_tready,
    input logic                 m_hdr_valid,
    input logic                 m_hdr_ready,
    input ip_addr_t             m_hdr_source_ip,
    input ip_addr_t             m_hdr_dest_ip,
    input udp_port_t            m_hdr_source_port,
    input udp_port_t            m_hdr_dest_port,
    input udp_len_t             m_hdr_length,
    input data_t                m_payload_tdata,
    input keep_t                m_payload_tkeep,
    input logic                 m_payload_tvalid,
    input logic                 m_payload_tready,
    input logic                 m_payload_tlast,
    input logic                 m_payload_tuser,
    input logic [LED_WIDTH-1:0] led
);

    udp_hdr_t             hdr_q [$];
    axis_beat_t           beat_q [$];
    logic [LED_WIDTH-1:0] led_q [$];
    logic [LED_WIDTH-1:0] led_want;
    logic                 led_due = 1'b0;
    logic                 in_frame = 1'b0;
    int                   input_beats = 0;
    int                   errors = 0;

    task automatic compare(input string what, input logic [63:0] got, input logic [63:0] want);
        if (got !== want) begin
            errors++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic expect_header(input udp_hdr_t h);
        hdr_q.push_back(h);
    endtask

    task automatic expect_beat(input axis_beat_t b);
        beat_q.push_back(b);
    endtask

    task automatic expect_led(input logic [LED_WIDTH-1:0] v);
        led_q.push_back(v);
    endtask

    task automatic clear_fill();
        input_beats = 0;
    endtask

    // FIFO full with the output stalled
    task automatic check_fill(input int want);
        compare("beats accepted with output stalled", input_beats, want);
        compare("payload ready with full FIFO", s_payload_tready, 1'b0);
    endtask

    task automatic check_idle();
        compare("reply valid after reset", m_hdr_valid, 1'b0);
        compare("payload valid after reset", m_payload_tvalid, 1'b0);
        compare("LED after reset", led, '0);
        compare("header ready after reset", s_hdr_ready, 1'b1);
        compare("payload ready after reset", s_payload_tready, 1'b1);
    endtask

    function automatic int pending();
        return hdr_q.size() + beat_q.size() + led_q.size() + int'(led_due);
    endfunction

    always @(posedge clk) begin
        udp_hdr_t   h;
        axis_beat_t b;
        if (!rst) begin
            // LED was latched on the previous edge
            if (led_due) begin
                compare("LED byte", led, led_want);
                led_due = 1'b0;
            end
            if (m_hdr_valid && m_hdr_ready) begin
                if (hdr_q.size() == 0) begin
                    errors++;
                    $display("Reply header at %0t came out with none expected", $time);
                end else begin
                    h = hdr_q.pop_front();
                    compare("reply source IP", m_hdr_source_ip, h.source_ip);
                    compare("reply dest IP", m_hdr_dest_ip, h.dest_ip);
                    compare("reply source port", m_hdr_source_port, h.source_port);
                    compare("reply dest port", m_hdr_dest_port, h.dest_port);
                    compare("reply length", m_hdr_length, h.length);
                end
            end
            if (m_payload_tvalid && m_payload_tready) begin
                if (beat_q.size() == 0) begin
                    errors++;
                    $display("Payload beat at %0t came out with none expected", $time);
                end else begin
                    b = beat_q.pop_front();
                    compare("payload data", m_payload_tdata, b.data);
                    compare("payload keep", m_payload_tkeep, b.keep);
                    compare("payload last", m_payload_tlast, b.last);
                    compare("payload user", m_payload_tuser, b.user);
                    if (!in_frame && led_q.size() != 0) begin
                        led_due  = 1'b1;
                        led_want = led_q.pop_front();
                    end
                    in_frame = !b.last;
                end
            end
            if (s_payload_tvalid && s_payload_tready) begin
                input_beats++;
            end
        end
    end

endmodule

`default_nettype wire

/* tests/tb_udp_loopback.sv */
// Loop-back testbench with clock, reset, file stimulus, random back-pressure and timeout
`timescale 1ns/1ns
`default_nettype none

module tb_udp_loopback import udp_pkg::*, axis_pkg::*; ();

    localparam int       FIFO_DEPTH  = 16;
    localparam int       MODE_OPEN   = 0;
    localparam int       MODE_RANDOM = 1;
    localparam int       MODE_HOLD   = 2;
    localparam ip_addr_t LOCAL_IP    = 32'h0a00_0080;

    logic clk, rst;
    logic s_hdr_valid, s_hdr_ready, m_hdr_valid, m_hdr_ready;
    ip_addr_t  s_hdr_source_ip, s_hdr_dest_ip, m_hdr_source_ip, m_hdr_dest_ip;
    udp_port_t s_hdr_source_port, s_hdr_dest_port, m_hdr_source_port, m_hdr_dest_port;
    udp_len_t  s_hdr_length, m_hdr_length;
    data_t     s_payload_tdata, m_payload_tdata;
    keep_t     s_payload_tkeep, m_payload_tkeep;
    logic s_payload_tvalid, s_payload_tready, s_payload_tlast, s_payload_tuser;
    logic m_payload_tvalid, m_payload_tready, m_payload_tlast, m_payload_tuser;
    logic [LED_WIDTH-1:0] led;

    // Stimulus and expectations from the data file
    udp_hdr_t             rx_hdrs [$];
    udp_hdr_t             reply_hdrs [$];
    logic [LED_WIDTH-1:0] led_bytes [$];
    axis_beat_t           beats [$];

    logic [31:0] rng;
    int ready_mode, cycles, cycle_limit, tests_run, tests_bad, err_mark;
    logic stim_ok;

    udp_loopback_top #(.FIFO_DEPTH(FIFO_DEPTH)) u_udp_loopback_top (.*, .local_ip(LOCAL_IP));

    tb_loopback_checker u_checker (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Output back-pressure
    always @(negedge clk) begin
        if (ready_mode == MODE_RANDOM) begin
            rng              = xorshift32(rng);
            m_hdr_ready      = rng[3];
            m_payload_tready = rng[7] | rng[11];
        end else begin
            m_hdr_ready      = 1'b1;
            m_payload_tready = (ready_mode != MODE_HOLD);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run stalled after %0d cycles with output still pending", cycles);
            $display("test failed");
            $finish;
        end
    end

    task automatic load_stimulus();
        int fd, n, left;
        string line;
        byte tag;
        logic [63:0] v [12];
        udp_hdr_t h, r;
        axis_beat_t b;
        left = 0;
        fd = $fopen("tests/loopback_input.txt", "r");
        if (fd == 0) begin
            stim_ok = 1'b0;
            $display("Could not open the stimulus file tests/loopback_input.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                tag = line.getc(0);
                if (tag == "F") begin
                    n = $sscanf(line, "%c %h %h %h %h %h %d %h %h %h %h %h %h", tag, v[0],
                                v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10],
                                v[11]);
                    stim_ok = stim_ok && (n == 13) && (left == 0);
                    h = {v[4][15:0], v[3][15:0], v[2][15:0], v[1][31:0], v[0][31:0]};
                    r = {v[10][15:0], v[9][15:0], v[8][15:0], v[7][31:0], v[6][31:0]};
                    rx_hdrs.push_back(h);
                    reply_hdrs.push_back(r);
                    led_bytes.push_back(v[11][7:0]);
                    left = int'(v[5]);
                end else if (tag == "B") begin
                    n = $sscanf(line, "%c %h %h %h", tag, v[0], v[1], v[2]);
                    stim_ok = stim_ok && (n == 4) && (left > 0);
                    b.data = v[0];
                    b.keep = v[1][7:0];
                    b.user = v[2][0];
                    b.last = (left == 1);
                    beats.push_back(b);
                    left--;
                end
            end
            $fclose(fd);
            stim_ok = stim_ok && (left == 0) && (rx_hdrs.size() != 0);
            if (!stim_ok) begin
                $display("Stimulus file is malformed or holds no complete frame");
            end
        end
        cycle_limit = 40 * beats.size() + 200;
    endtask

    task automatic send_headers();
        foreach (rx_hdrs[i]) begin
            s_hdr_valid       = 1'b1;
            s_hdr_source_ip   = rx_hdrs[i].source_ip;
            s_hdr_dest_ip     = rx_hdrs[i].dest_ip;
            s_hdr_source_port = rx_hdrs[i].source_port;
            s_hdr_dest_port   = rx_hdrs[i].dest_port;
            s_hdr_length      = rx_hdrs[i].length;
            @(posedge clk);
            while (!s_hdr_ready) @(posedge clk);
            @(negedge clk);
        end
        s_hdr_valid = 1'b0;
    endtask

    task automatic send_payload();
        foreach (beats[i]) begin
            s_payload_tvalid = 1'b1;
            s_payload_tdata  = beats[i].data;
            s_payload_tkeep  = beats[i].keep;
            s_payload_tlast  = beats[i].last;
            s_payload_tuser  = beats[i].user;
            @(posedge clk);
            while (!s_payload_tready) @(posedge clk);
            @(negedge clk);
        end
        s_payload_tvalid = 1'b0;
    endtask

    // Queue every record's expectations, then drive both paths at once
    task automatic run_frames();
        foreach (reply_hdrs[i]) u_checker.expect_header(reply_hdrs[i]);
        foreach (beats[i]) u_checker.expect_beat(beats[i]);
        foreach (led_bytes[i]) u_checker.expect_led(led_bytes[i]);
        fork
            send_headers();
            send_payload();
        join
    endtask

    task automatic watch_fill();
        @(negedge clk);
        while (s_payload_tready) @(negedge clk);
        u_checker.check_fill(FIFO_DEPTH);
        repeat (3) @(negedge clk);
        u_checker.check_fill(FIFO_DEPTH);
        @(posedge clk);
        ready_mode = MODE_OPEN;
    endtask

    task automatic wait_drained();
        @(negedge clk);
        while (u_checker.pending() != 0) @(negedge clk);
        repeat (2) @(negedge clk);
    endtask

    task automatic close_test(input string name);
        int errs;
        errs = u_checker.errors - err_mark;
        err_mark = u_checker.errors;
        tests_run++;
        if (errs == 0) begin
            $display("%-28s ok", name);
        end else begin
            tests_bad++;
            $display("%-28s FAILED with %0d errors", name, errs);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        s_hdr_valid = 1'b0;
        {s_hdr_source_ip, s_hdr_dest_ip, s_hdr_source_port, s_hdr_dest_port} = '0;
        s_hdr_length = '0;
        {s_payload_tdata, s_payload_tkeep, s_payload_tvalid} = '0;
        {s_payload_tlast, s_payload_tuser} = '0;
        m_hdr_ready = 1'b1;
        m_payload_tready = 1'b1;
        rng = 32'hdb17;
        {cycles, tests_run, tests_bad, err_mark} = '0;
        cycle_limit = 200;
        ready_mode = MODE_OPEN;
        stim_ok = 1'b1;
        load_stimulus();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        u_checker.check_idle();
        close_test("reset state");
        if (stim_ok) begin
            run_frames();
            wait_drained();
            close_test("in-order loop-back");
            @(posedge clk);
            ready_mode = MODE_RANDOM;
            @(negedge clk);
            run_frames();
            wait_drained();
            close_test("random back-pressure");
            @(posedge clk);
            ready_mode = MODE_HOLD;
            @(negedge clk);
            u_checker.clear_fill();
            fork
                run_frames();
                watch_fill();
            join
            wait_drained();
            close_test("FIFO fill to depth");
        end
        $display("Summary: %0d tests, %0d failing, %0d errors, %0d cycles",
                 tests_run, tests_bad, u_checker.errors, cycles);
        if (tests_bad == 0 && stim_ok) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* udp_loopback_top.f */
src/udp_pkg.sv
src/axis_pkg.sv
src/axis_if.sv
src/udp_hdr_responder.sv
src/udp_payload_fifo.sv
src/frame_led_capture.sv
src/udp_loopback_top.sv
tests/tb_loopback_checker.sv
tests/tb_udp_loopback.sv
